// ==== all.f ====
verilog/ttc_apb_pkg.sv
verilog/ttc_count_pkg.sv
verilog/ttc_apb_decode.sv
verilog/ttc_count_rst_lite.sv
verilog/ttc_counter_exec.sv
verilog/ttc_int_result.sv
verilog/ttc_lite.sv
tests/tb_clkgen.sv
tests/tb_checker.sv
tests/tb_ttc_lite.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the timer testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ttc_lite \
  -Mdir obj_dir -o sim -f all.f > build.log 2>&1 \
  && ./obj_dir/sim > sim.log 2>&1 \
  || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "^TB PASSED$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// ==== tests/tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  wire                         pclk4,
  input  wire                         psel,
  input  wire                         penable,
  input  wire                         pwrite,
  input  wire ttc_apb_pkg::apb_addr_t paddr,
  input  wire ttc_apb_pkg::apb_data_t prdata,
  input  wire                         irq,
  input  wire                         exp_valid,
  input  wire ttc_apb_pkg::apb_data_t exp_data,
  input  wire ttc_apb_pkg::apb_data_t exp_mask,
  input  wire                         chk_irq,
  input  wire                         exp_irq,
  input  wire [7:0]                   test_num,
  input  wire                         tests_done,
  output int                          check_cnt,
  output int                          error_cnt
);

  int         test_checks;
  int         test_errors;
  logic [7:0] cur_test;
  logic       reported;

  initial
  begin
    check_cnt   = 0;
    error_cnt   = 0;
    test_checks = 0;
    test_errors = 0;
    cur_test    = 8'd0;
    reported    = 1'b0;
  end

  // one summary line per test, test 0 is the reset stretch
  task automatic report_test();
    if (cur_test != 8'd0)
      $display("test %0d done: %0d checks, %0d errors", cur_test, test_checks, test_errors);
  endtask

  // ------------------------------------------------------------
  // sample mid low phase, clear of both clock edges
  // ------------------------------------------------------------
  always @(negedge pclk4)
  begin
    #2;
    if (test_num != cur_test)
    begin
      report_test();
      cur_test    = test_num;
      test_checks = 0;
      test_errors = 0;
    end
    // read access phase with an expectation attached
    if (psel && penable && !pwrite && exp_valid)
    begin
      check_cnt   = check_cnt + 1;
      test_checks = test_checks + 1;
      if ((prdata & exp_mask) != (exp_data & exp_mask))
      begin
        error_cnt   = error_cnt + 1;
        test_errors = test_errors + 1;
        $display("** Error at %0t: test %0d, read of 0x%h expected 0x%h got 0x%h", $time,
                 test_num, paddr, exp_data & exp_mask, prdata & exp_mask);
      end
      if (chk_irq && (irq !== exp_irq))
      begin
        error_cnt   = error_cnt + 1;
        test_errors = test_errors + 1;
        $display("** Error at %0t: test %0d, irq expected %b got %b", $time,
                 test_num, exp_irq, irq);
      end
    end
    if (tests_done && !reported)
    begin
      report_test();
      reported = 1'b1;
      $display("checks %0d, errors %0d", check_cnt, error_cnt);
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk
);

  // starts low, first rising edge half a period in
  initial
  begin
    clk = 1'b0;
  end

  always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

`default_nettype wire

// ==== tests/tb_ttc_lite.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ttc_lite;

  import ttc_apb_pkg::*;
  import ttc_count_pkg::*;

  localparam int CNT_WIDTH   = CNT_WIDTH_DEF;
  // rough length of the whole run in cycles
  localparam int TEST_CYCLES = 4000;
  // limit at twice the run length
  localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

  logic       pclk4;
  logic       n_p_reset4;
  logic       psel;
  logic       penable;
  logic       pwrite;
  apb_addr_t  paddr;
  apb_data_t  pwdata;
  apb_data_t  prdata;
  logic       irq;

  // expectation handed to the checker
  logic       exp_valid;
  apb_data_t  exp_data;
  apb_data_t  exp_mask;
  logic       chk_irq;
  logic       exp_irq;
  logic [7:0] test_num;
  logic       tests_done;
  int         check_cnt;
  int         error_cnt;

  logic [31:0] lfsr_state = 32'h7200;
  // rising edges seen so far
  int          cyc = 0;
  int          timeout_cnt;
  int          wr_edge;

  // counter setup as the model sees it
  logic        cfg_iv;
  logic        cfg_decr;
  logic        cfg_pre_en;
  prescale_t   cfg_pre_val;
  int          cfg_interval;
  // edge that cleared the counter
  int          clr_edge;
  // edges counted before a disable or -1 while running
  int          frozen_n;

  apb_addr_t rw_addrs [4] = '{ADDR_CLK_CTRL, ADDR_INTERVAL, ADDR_MATCH, ADDR_INT_EN};

  tb_clkgen #(
    .PERIOD_NS (8.0)
  ) u_clkgen (
    .clk (pclk4)
  );

  ttc_lite #(
    .CNT_WIDTH (CNT_WIDTH)
  ) uut (
    .pclk4      (pclk4),
    .n_p_reset4 (n_p_reset4),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .irq        (irq)
  );

  tb_checker u_checker (
    .pclk4      (pclk4),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .prdata     (prdata),
    .irq        (irq),
    .exp_valid  (exp_valid),
    .exp_data   (exp_data),
    .exp_mask   (exp_mask),
    .chk_irq    (chk_irq),
    .exp_irq    (exp_irq),
    .test_num   (test_num),
    .tests_done (tests_done),
    .check_cnt  (check_cnt),
    .error_cnt  (error_cnt)
  );

  always @(posedge pclk4)
    cyc <= cyc + 1;

  // ------------------------------------------------------------
  // random bits and the reference model
  // ------------------------------------------------------------
  // feedback taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      r          = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic apb_data_t low_ones(input int w);
    return apb_data_t'((64'd1 << w) - 64'd1);
  endfunction

  // writable bits per register with none for read only or unmapped
  function automatic apb_data_t writable_mask(input apb_addr_t addr);
    case (addr)
      ADDR_CLK_CTRL:  return low_ones(7);
      ADDR_CNTR_CTRL: return low_ones(5);
      ADDR_INTERVAL:  return low_ones(CNT_WIDTH);
      ADDR_MATCH:     return low_ones(CNT_WIDTH);
      ADDR_INT_EN:    return low_ones(2);
      default:        return '0;
    endcase
  endfunction

  function automatic apb_data_t ctrl_word(input bit dis, input bit ivm, input bit decr,
                                          input bit mat, input bit rst);
    apb_data_t w;
    w                = '0;
    w[CTRL_DIS]      = dis;
    w[CTRL_INTERVAL] = ivm;
    w[CTRL_DECR]     = decr;
    w[CTRL_MATCH]    = mat;
    w[CTRL_RESTART]  = rst;
    return w;
  endfunction

  // counter after n counting edges from a clear
  function automatic apb_data_t ref_count(input int n);
    int                   ticks;
    int                   period;
    logic [CNT_WIDTH-1:0] val;
    // prescaler lets one edge in 2^(pre_val+1) through
    ticks = cfg_pre_en ? (n >> (int'(cfg_pre_val) + 1)) : n;
    if (cfg_iv)
    begin
      period = cfg_interval + 1;
      if (cfg_decr)
        val = CNT_WIDTH'(cfg_interval - (ticks % period));
      else
        val = CNT_WIDTH'(ticks % period);
    end
    else
      val = cfg_decr ? CNT_WIDTH'(-ticks) : CNT_WIDTH'(ticks);
    return apb_data_t'(val);
  endfunction

  // ------------------------------------------------------------
  // apb driver changing signals on the falling edge
  // ------------------------------------------------------------
  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    @(negedge pclk4);
    psel      = 1'b1;
    penable   = 1'b0;
    pwrite    = 1'b1;
    paddr     = addr;
    pwdata    = data;
    exp_valid = 1'b0;
    chk_irq   = 1'b0;
    @(negedge pclk4);
    penable = 1'b1;
    // the coming rising edge stores the data
    wr_edge = cyc + 1;
  endtask

  task automatic apb_read(input apb_addr_t addr, input apb_data_t exp, input apb_data_t mask,
                          input bit count_rd, input bit irq_chk, input bit irq_exp);
    @(negedge pclk4);
    psel      = 1'b1;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = addr;
    exp_valid = 1'b1;
    exp_data  = exp;
    exp_mask  = mask;
    chk_irq   = irq_chk;
    exp_irq   = irq_exp;
    @(negedge pclk4);
    penable = 1'b1;
    if (count_rd)
      exp_data = ref_count((frozen_n >= 0) ? frozen_n : cyc - clr_edge);
  endtask

  task automatic read_count();
    apb_read(ADDR_COUNT, '0, '1, 1'b1, 1'b0, 1'b0);
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(negedge pclk4);
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      exp_valid = 1'b0;
      chk_irq   = 1'b0;
    end
  endtask

  task automatic set_clock(input bit pre_en, input prescale_t pre_val);
    apb_write(ADDR_CLK_CTRL, (apb_data_t'(pre_val) << CLK_PRE_VAL) |
                             (apb_data_t'(pre_en) << CLK_PRE_EN));
    cfg_pre_en  = pre_en;
    cfg_pre_val = pre_val;
  endtask

  // rearm and then the 0 to 1 edge of the restart bit
  task automatic restart_counter(input bit ivm, input bit decr, input bit mat);
    apb_write(ADDR_CNTR_CTRL, ctrl_word(1'b0, ivm, decr, mat, 1'b0));
    apb_write(ADDR_CNTR_CTRL, ctrl_word(1'b0, ivm, decr, mat, 1'b1));
    clr_edge = wr_edge + 1;
    cfg_iv   = ivm;
    cfg_decr = decr;
    frozen_n = -1;
  endtask

  // ------------------------------------------------------------
  // tests
  // ------------------------------------------------------------
  initial
  begin
    apb_data_t d;
    apb_addr_t a;
    int        i;
    int        iv;
    int        mv;
    int        a_edge;
    int        dir;
    n_p_reset4 = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    exp_valid  = 1'b0;
    exp_data   = '0;
    exp_mask   = '0;
    chk_irq    = 1'b0;
    exp_irq    = 1'b0;
    test_num   = 8'd0;
    tests_done = 1'b0;
    frozen_n   = -1;
    repeat (10) @(posedge pclk4);
    @(negedge pclk4);
    n_p_reset4 = 1'b1;
    idle(2);

    // register readback and unmapped reads
    test_num = 8'd1;
    for (i = 0; i < 24; i++)
    begin
      d = rand_bits(32);
      apb_write(rw_addrs[i % 4], d);
      apb_read(rw_addrs[i % 4], d & writable_mask(rw_addrs[i % 4]), '1, 1'b0, 1'b0, 1'b0);
    end
    apb_read(8'h1C, '0, '1, 1'b0, 1'b0, 1'b0);
    for (i = 0; i < 4; i++)
    begin
      d = rand_bits(7);
      a = {1'b1, d[6:0]};
      apb_read(a, '0, '1, 1'b0, 1'b0, 1'b0);
    end

    // restart while disabled and a short run frozen by disable
    test_num = 8'd2;
    set_clock(1'b0, 4'd0);
    apb_write(ADDR_CNTR_CTRL, ctrl_word(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
    apb_write(ADDR_CNTR_CTRL, ctrl_word(1'b1, 1'b0, 1'b0, 1'b0, 1'b1));
    cfg_iv   = 1'b0;
    cfg_decr = 1'b0;
    frozen_n = 0;
    read_count();
    apb_write(ADDR_CNTR_CTRL, ctrl_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
    a_edge = wr_edge;
    idle(int'(rand_bits(5)));
    apb_write(ADDR_CNTR_CTRL, ctrl_word(1'b1, 1'b0, 1'b0, 1'b0, 1'b1));
    frozen_n = wr_edge - a_edge;
    idle(1 + int'(rand_bits(5)));
    read_count();
    idle(1 + int'(rand_bits(5)));
    read_count();

    // interval wrap with status, irq and clear on read
    test_num = 8'd3;
    iv = 3 + int'(rand_bits(4));
    cfg_interval = iv;
    apb_write(ADDR_INTERVAL, apb_data_t'(iv));
    apb_write(ADDR_INT_EN, apb_data_t'(1 << INT_IV));
    restart_counter(1'b1, 1'b0, 1'b0);
    repeat (6)
    begin
      idle(int'(rand_bits(3)));
      read_count();
    end
    idle(2 * iv + 4);
    apb_write(ADDR_CNTR_CTRL, ctrl_word(1'b1, 1'b1, 1'b0, 1'b0, 1'b1));
    apb_read(ADDR_INT_STAT, apb_data_t'(1 << INT_IV), 32'h3, 1'b0, 1'b1, 1'b1);
    apb_read(ADDR_INT_STAT, '0, 32'h3, 1'b0, 1'b0, 1'b0);

    // match with both interrupts masked
    test_num = 8'd4;
    iv = 4 + int'(rand_bits(4));
    mv = 1 + (int'(rand_bits(4)) % (iv - 1));
    cfg_interval = iv;
    apb_write(ADDR_INTERVAL, apb_data_t'(iv));
    apb_write(ADDR_MATCH, apb_data_t'(mv));
    apb_write(ADDR_INT_EN, '0);
    restart_counter(1'b1, 1'b0, 1'b1);
    repeat (3)
    begin
      idle(int'(rand_bits(3)));
      read_count();
    end
    idle(2 * iv + 4);
    apb_write(ADDR_CNTR_CTRL, ctrl_word(1'b1, 1'b1, 1'b0, 1'b1, 1'b1));
    apb_read(ADDR_INT_STAT, 32'h3, 32'h3, 1'b0, 1'b1, 1'b0);
    apb_read(ADDR_INT_STAT, '0, 32'h3, 1'b0, 1'b1, 1'b0);

    // free-running with prescaler up and then down
    test_num = 8'd5;
    for (dir = 0; dir < 2; dir++)
    begin
      set_clock(1'b1, prescale_t'(rand_bits(2)));
      restart_counter(1'b0, dir[0], 1'b0);
      idle(int'(rand_bits(4)));
      read_count();
      idle(16 + int'(rand_bits(6)));
      read_count();
    end

    idle(2);
    tests_done = 1'b1;
    idle(2);
    if (error_cnt == 0 && check_cnt > 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  // run limit
  initial
  begin
    timeout_cnt = 0;
    while (timeout_cnt < MAX_CYCLES)
    begin
      @(posedge pclk4);
      timeout_cnt = timeout_cnt + 1;
    end
    $display("timeout: tests did not finish");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/ttc_apb_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module ttc_apb_decode #(
  parameter int CNT_WIDTH = ttc_count_pkg::CNT_WIDTH_DEF
) (
  input  wire                           pclk4,
  input  wire                           n_p_reset4,
  input  wire                           psel,
  input  wire                           penable,
  input  wire                           pwrite,
  input  wire ttc_apb_pkg::apb_addr_t   paddr,
  input  wire ttc_apb_pkg::apb_data_t   pwdata,
  output ttc_apb_pkg::apb_data_t        prdata,
  input  wire ttc_count_pkg::clk_ctrl_t clk_ctrl,
  input  wire [CNT_WIDTH-1:0]           count_val,
  input  wire ttc_count_pkg::int_vec_t  int_stat,
  output logic                          clk_ctrl_sel,
  output logic                          restart,
  output logic                          ctrl_dis,
  output logic                          ctrl_interval,
  output logic                          ctrl_decr,
  output logic                          ctrl_match,
  output logic [CNT_WIDTH-1:0]          interval,
  output logic [CNT_WIDTH-1:0]          match_val,
  output ttc_count_pkg::int_vec_t       int_en,
  output logic                          int_stat_rd
);

  import ttc_apb_pkg::*;
  import ttc_count_pkg::*;

  // access phase qualifiers
  logic       wr_en;
  logic       rd_en;
  cntr_ctrl_t cntr_ctrl;

  // ------------------------------------------------------------
  // strobes
  // ------------------------------------------------------------
  // zero wait states, every access phase completes
  assign wr_en = psel & penable & pwrite;
  assign rd_en = psel & penable & ~pwrite;

  // clock control lives in the restart block
  assign clk_ctrl_sel = wr_en & (paddr == ADDR_CLK_CTRL);
  // status clears on this read
  assign int_stat_rd  = rd_en & (paddr == ADDR_INT_STAT);

  // control fields out to the counter
  assign ctrl_dis      = cntr_ctrl[CTRL_DIS];
  assign ctrl_interval = cntr_ctrl[CTRL_INTERVAL];
  assign ctrl_decr     = cntr_ctrl[CTRL_DECR];
  assign ctrl_match    = cntr_ctrl[CTRL_MATCH];
  // level, the restart block finds the edge
  assign restart       = cntr_ctrl[CTRL_RESTART];

  // ------------------------------------------------------------
  // register file
  // ------------------------------------------------------------
  always_ff @(posedge pclk4 or negedge n_p_reset4)
  begin
    if (!n_p_reset4)
    begin
      cntr_ctrl <= '0;
      interval  <= '0;
      match_val <= '0;
      int_en    <= '0;
    end
    else if (wr_en)
    begin
      // write lands on the access edge
      case (paddr)
        ADDR_CNTR_CTRL: cntr_ctrl <= pwdata[$bits(cntr_ctrl_t)-1:0];
        ADDR_INTERVAL:  interval  <= pwdata[CNT_WIDTH-1:0];
        ADDR_MATCH:     match_val <= pwdata[CNT_WIDTH-1:0];
        ADDR_INT_EN:    int_en    <= pwdata[$bits(int_vec_t)-1:0];
        default:        ;
      endcase
    end
  end

  // ------------------------------------------------------------
  // read mux
  // ------------------------------------------------------------
  always_comb
  begin
    prdata = '0;
    // only driven during a read access phase
    if (rd_en)
    begin
      case (paddr)
        ADDR_CLK_CTRL:  prdata[$bits(clk_ctrl_t)-1:0]  = clk_ctrl;
        ADDR_CNTR_CTRL: prdata[$bits(cntr_ctrl_t)-1:0] = cntr_ctrl;
        ADDR_COUNT:     prdata[CNT_WIDTH-1:0]          = count_val;
        ADDR_INTERVAL:  prdata[CNT_WIDTH-1:0]          = interval;
        ADDR_MATCH:     prdata[CNT_WIDTH-1:0]          = match_val;
        ADDR_INT_STAT:  prdata[$bits(int_vec_t)-1:0]   = int_stat;
        ADDR_INT_EN:    prdata[$bits(int_vec_t)-1:0]   = int_en;
        // unmapped reads return zero
        default:        prdata = '0;
      endcase
    end
  end

  // bus stays quiet outside a read access
  a_prdata_idle: assert property (
    @(posedge pclk4) disable iff (!n_p_reset4)
    !(psel && penable && !pwrite) |-> (prdata == '0)
  ) else $error("prdata driven outside a read access phase");

endmodule

`default_nettype wire

// ==== verilog/ttc_apb_pkg.sv ====
`default_nettype none

// ------------------------------------------------------------
// apb side of the timer: bus widths and register map
// ------------------------------------------------------------
package ttc_apb_pkg;

  // byte address, only the low 8 bits are decoded
  typedef logic [7:0] apb_addr_t;

  // apb data word
  typedef logic [31:0] apb_data_t;

  // register offsets
  // clock control, 7 bits
  localparam apb_addr_t ADDR_CLK_CTRL  = 8'h00;
  // counter control, 5 bits
  localparam apb_addr_t ADDR_CNTR_CTRL = 8'h04;
  // counter value, read only
  localparam apb_addr_t ADDR_COUNT     = 8'h08;
  // interval compare value
  localparam apb_addr_t ADDR_INTERVAL  = 8'h0C;
  // match compare value
  localparam apb_addr_t ADDR_MATCH     = 8'h10;
  // interrupt status, read only, cleared by the read
  localparam apb_addr_t ADDR_INT_STAT  = 8'h14;
  // interrupt enable mask
  localparam apb_addr_t ADDR_INT_EN    = 8'h18;

endpackage

`default_nettype wire

// ==== verilog/ttc_count_pkg.sv ====
`default_nettype none

// ------------------------------------------------------------
// counter side of the timer: control words and bit positions
// ------------------------------------------------------------
package ttc_count_pkg;

  // clock control register, bits 6:5 kept for readback only
  typedef logic [6:0] clk_ctrl_t;

  // prescale select, divides by 2^(val+1)
  typedef logic [3:0] prescale_t;

  // counter control register
  typedef logic [4:0] cntr_ctrl_t;

  // one bit per interrupt source
  typedef logic [1:0] int_vec_t;

  // counter width unless the top level says otherwise
  localparam int CNT_WIDTH_DEF = 16;

  // clock control fields
  localparam int CLK_PRE_EN  = 0;
  // lsb of the 4-bit prescale value
  localparam int CLK_PRE_VAL = 1;

  // counter control fields
  localparam int CTRL_DIS      = 0;
  localparam int CTRL_INTERVAL = 1;
  localparam int CTRL_DECR     = 2;
  localparam int CTRL_MATCH    = 3;
  localparam int CTRL_RESTART  = 4;

  // interrupt sources
  // interval wrap or free-running overflow
  localparam int INT_IV    = 0;
  localparam int INT_MATCH = 1;

endpackage

`default_nettype wire

// ==== verilog/ttc_count_rst_lite.sv ====
`timescale 1ns/1ps
`default_nettype none

module ttc_count_rst_lite (
  input  wire                           pclk4,
  input  wire                           n_p_reset4,
  input  wire ttc_count_pkg::clk_ctrl_t pwdata,
  input  wire                           clk_ctrl_sel,
  input  wire                           restart,
  output logic                          count_en,
  output ttc_count_pkg::clk_ctrl_t      clk_ctrl
);

  import ttc_count_pkg::*;

  // restart already seen, held until software clears it
  logic restart_var;
  // low for the first cycle out of reset
  logic run_q;
  // first cycle of a restart level
  logic restart_edge;

  // ------------------------------------------------------------
  // restart edge and count enable
  // ------------------------------------------------------------
  assign restart_edge = restart & ~restart_var;

  // one low cycle per restart, that edge clears the counter
  assign count_en = run_q & ~restart_edge;

  always_ff @(posedge pclk4 or negedge n_p_reset4)
  begin
    if (!n_p_reset4)
    begin
      restart_var <= 1'b0;
      run_q       <= 1'b0;
    end
    else
    begin
      run_q <= 1'b1;
      // arm on the edge, rearm only once restart drops
      if (restart_edge)
        restart_var <= 1'b1;
      else if (!restart)
        restart_var <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // clock control register
  // ------------------------------------------------------------
  always_ff @(posedge pclk4 or negedge n_p_reset4)
  begin
    if (!n_p_reset4)
      clk_ctrl <= '0;
    else if (clk_ctrl_sel)
      clk_ctrl <= pwdata;
  end

  // the clear cycle never stretches
  a_count_en_pulse: assert property (
    @(posedge pclk4) disable iff (!n_p_reset4)
    !count_en |=> count_en
  ) else $error("count_en low for two cycles");

endmodule

`default_nettype wire

// ==== verilog/ttc_counter_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module ttc_counter_exec #(
  parameter int CNT_WIDTH = ttc_count_pkg::CNT_WIDTH_DEF
) (
  input  wire                           pclk4,
  input  wire                           n_p_reset4,
  input  wire ttc_count_pkg::clk_ctrl_t clk_ctrl,
  input  wire                           count_en,
  input  wire                           ctrl_dis,
  input  wire                           ctrl_interval,
  input  wire                           ctrl_decr,
  input  wire                           ctrl_match,
  input  wire [CNT_WIDTH-1:0]           interval,
  input  wire [CNT_WIDTH-1:0]           match_val,
  output logic [CNT_WIDTH-1:0]          count_val,
  output logic                          iv_event,
  output logic                          match_event
);

  import ttc_count_pkg::*;

  localparam logic [CNT_WIDTH-1:0] CNT_MAX = '1;

  prescale_t            pre_val;
  logic                 pre_en;
  logic [15:0]          pre_cnt;
  logic [15:0]          pre_mask;
  logic                 run;
  logic                 tick;
  logic                 wrap;
  logic [CNT_WIDTH-1:0] cnt_nxt;
  logic [CNT_WIDTH-1:0] reload;

  // ------------------------------------------------------------
  // prescaler
  // ------------------------------------------------------------
  assign pre_val = clk_ctrl[CLK_PRE_VAL +: $bits(prescale_t)];
  assign pre_en  = clk_ctrl[CLK_PRE_EN];
  assign run     = count_en & ~ctrl_dis;

  // low pre_val+1 bits set, wraps to all ones for 15
  assign pre_mask = (16'd2 << pre_val) - 16'd1;

  // every enabled edge, or one in 2^(pre_val+1)
  assign tick = run & (~pre_en | ((pre_cnt & pre_mask) == pre_mask));

  always_ff @(posedge pclk4 or negedge n_p_reset4)
  begin
    if (!n_p_reset4)
      pre_cnt <= '0;
    else if (!count_en)
      pre_cnt <= '0;
    else if (run)
      pre_cnt <= pre_cnt + 16'd1;
  end

  // ------------------------------------------------------------
  // main counter
  // ------------------------------------------------------------
  // restart value, interval when counting down in interval mode
  assign reload = (ctrl_interval & ctrl_decr) ? interval : '0;

  always_comb
  begin
    wrap    = 1'b0;
    cnt_nxt = count_val;
    if (ctrl_decr)
    begin
      // down, wrap at zero
      if (count_val == '0)
      begin
        wrap    = 1'b1;
        cnt_nxt = ctrl_interval ? interval : CNT_MAX;
      end
      else
        cnt_nxt = count_val - 1'b1;
    end
    else
    begin
      // up, wrap at interval or at all ones
      if (ctrl_interval ? (count_val >= interval) : (count_val == CNT_MAX))
      begin
        wrap    = 1'b1;
        cnt_nxt = '0;
      end
      else
        cnt_nxt = count_val + 1'b1;
    end
  end

  always_ff @(posedge pclk4 or negedge n_p_reset4)
  begin
    if (!n_p_reset4)
      count_val <= '0;
    else if (!count_en)
      count_val <= reload;
    else if (tick)
      count_val <= cnt_nxt;
  end

  // events flag the tick that wraps or lands on match
  assign iv_event    = tick & wrap;
  assign match_event = tick & ctrl_match & (cnt_nxt == match_val);

  // restart cycle is a clear, nothing counts or fires
  a_no_tick_in_clear: assert property (
    @(posedge pclk4) disable iff (!n_p_reset4)
    !count_en |-> !(tick || iv_event)
  ) else $error("counter activity during restart clear");

endmodule

`default_nettype wire

// ==== verilog/ttc_int_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module ttc_int_result (
  input  wire                          pclk4,
  input  wire                          n_p_reset4,
  input  wire                          iv_event,
  input  wire                          match_event,
  input  wire ttc_count_pkg::int_vec_t int_en,
  input  wire                          int_stat_rd,
  output ttc_count_pkg::int_vec_t      int_stat,
  output logic                         irq
);

  import ttc_count_pkg::*;

  // events gathered into status bit order
  int_vec_t events;

  always_comb
  begin
    events            = '0;
    events[INT_IV]    = iv_event;
    events[INT_MATCH] = match_event;
  end

  // ------------------------------------------------------------
  // status and irq
  // ------------------------------------------------------------
  always_ff @(posedge pclk4 or negedge n_p_reset4)
  begin
    if (!n_p_reset4)
    begin
      int_stat <= '0;
      irq      <= 1'b0;
    end
    else
    begin
      // read clears, an event on the same edge still lands
      int_stat <= (int_stat_rd ? int_vec_t'(0) : int_stat) | events;
      // masked, one edge behind status
      irq      <= |(int_stat & int_en);
    end
  end

  // irq only follows an enabled, set status bit
  a_irq_cause: assert property (
    @(posedge pclk4) disable iff (!n_p_reset4)
    irq |-> $past(|(int_stat & int_en))
  ) else $error("irq without an enabled status bit");

endmodule

`default_nettype wire

// ==== verilog/ttc_lite.sv ====
`timescale 1ns/1ps
`default_nettype none

module ttc_lite #(
  parameter int CNT_WIDTH = ttc_count_pkg::CNT_WIDTH_DEF
) (
  input  wire                         pclk4,
  input  wire                         n_p_reset4,
  input  wire                         psel,
  input  wire                         penable,
  input  wire                         pwrite,
  input  wire ttc_apb_pkg::apb_addr_t paddr,
  input  wire ttc_apb_pkg::apb_data_t pwdata,
  output ttc_apb_pkg::apb_data_t      prdata,
  output logic                        irq
);

  import ttc_count_pkg::*;

  // ------------------------------------------------------------
  // block to block wires
  // ------------------------------------------------------------
  clk_ctrl_t            clk_ctrl;
  logic                 clk_ctrl_sel;
  logic                 restart;
  logic                 count_en;
  logic                 ctrl_dis;
  logic                 ctrl_interval;
  logic                 ctrl_decr;
  logic                 ctrl_match;
  logic [CNT_WIDTH-1:0] interval;
  logic [CNT_WIDTH-1:0] match_val;
  logic [CNT_WIDTH-1:0] count_val;
  logic                 iv_event;
  logic                 match_event;
  int_vec_t             int_en;
  int_vec_t             int_stat;
  logic                 int_stat_rd;

  // apb registers and read mux
  ttc_apb_decode #(
    .CNT_WIDTH (CNT_WIDTH)
  ) u_decode (
    .pclk4         (pclk4),
    .n_p_reset4    (n_p_reset4),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .clk_ctrl      (clk_ctrl),
    .count_val     (count_val),
    .int_stat      (int_stat),
    .clk_ctrl_sel  (clk_ctrl_sel),
    .restart       (restart),
    .ctrl_dis      (ctrl_dis),
    .ctrl_interval (ctrl_interval),
    .ctrl_decr     (ctrl_decr),
    .ctrl_match    (ctrl_match),
    .interval      (interval),
    .match_val     (match_val),
    .int_en        (int_en),
    .int_stat_rd   (int_stat_rd)
  );

  // clock control and restart edge
  ttc_count_rst_lite u_count_rst (
    .pclk4        (pclk4),
    .n_p_reset4   (n_p_reset4),
    .pwdata       (pwdata[$bits(clk_ctrl_t)-1:0]),
    .clk_ctrl_sel (clk_ctrl_sel),
    .restart      (restart),
    .count_en     (count_en),
    .clk_ctrl     (clk_ctrl)
  );

  // prescaler and counter
  ttc_counter_exec #(
    .CNT_WIDTH (CNT_WIDTH)
  ) u_exec (
    .pclk4         (pclk4),
    .n_p_reset4    (n_p_reset4),
    .clk_ctrl      (clk_ctrl),
    .count_en      (count_en),
    .ctrl_dis      (ctrl_dis),
    .ctrl_interval (ctrl_interval),
    .ctrl_decr     (ctrl_decr),
    .ctrl_match    (ctrl_match),
    .interval      (interval),
    .match_val     (match_val),
    .count_val     (count_val),
    .iv_event      (iv_event),
    .match_event   (match_event)
  );

  // interrupt status and irq
  ttc_int_result u_result (
    .pclk4       (pclk4),
    .n_p_reset4  (n_p_reset4),
    .iv_event    (iv_event),
    .match_event (match_event),
    .int_en      (int_en),
    .int_stat_rd (int_stat_rd),
    .int_stat    (int_stat),
    .irq         (irq)
  );

endmodule

`default_nettype wire
